// File: rtl/obs_config.svh
`ifndef OBS_CONFIG_SVH
`define OBS_CONFIG_SVH

// Trigger and lane counts
`define OBS_NUM_TRIG        4
`define OBS_NUM_LANES       4

// Circular trace buffer
`define OBS_TRACE_DEPTH     16
`define OBS_TRACE_AW        4

`define OBS_TS_W            32   // Free-running timestamp

// Wishbone, byte addressed
`define OBS_WB_AW           8
`define OBS_WB_DW           32

// Register map
`define OBS_REG_CTRL        8'h00
`define OBS_REG_COND_BASE   8'h04   // Four condition words, 4 bytes apart
`define OBS_REG_STATUS      8'h14
`define OBS_REG_TRACE_BASE  8'h80   // Two words per trace entry

// Trigger type codes, anything else never fires
`define OBS_TRIG_ERR        8'd1
`define OBS_TRIG_THERM      8'd4
`define OBS_TRIG_POWER      8'd5
`define OBS_TRIG_PROTO      8'd6
`define OBS_TRIG_LINK       8'd7

`endif

// File: rtl/obs_pkg.sv
`default_nettype none

package obs_pkg;

    // One trigger condition word, read two ways depending on the type code.
    // Threshold types use the upper 24 bits as the compare value, while the
    // link-training type only looks at a lane number.
    typedef union packed {
        struct packed {
            logic [23:0] threshold;   // Cut to the compared field's width
            logic [7:0]  trig_type;
        } thresh_view;
        struct packed {
            logic [21:0] unused;
            logic [1:0]  lane_sel;    // Lane whose link-up is watched
            logic [7:0]  trig_type;
        } lane_view;
    } trig_cond_u;

endpackage

`default_nettype wire

// File: rtl/obs_sample_capture.sv
`timescale 1ns/1ps
`default_nettype none

`include "obs_config.svh"

module obs_sample_capture (
    input  logic                       clk_management,
    input  logic                       rst_n,
    input  logic                       flit_valid,
    input  logic                       flit_error,
    input  logic [15:0]                flit_data,
    input  logic [7:0]                 err_cnt,
    input  logic [11:0]                therm_c,
    input  logic [15:0]                power_mw,
    input  logic [`OBS_NUM_LANES-1:0]  link_up,
    output logic                       s_valid,
    output logic                       s_error,
    output logic [15:0]                s_data,
    output logic [7:0]                 s_err_cnt,
    output logic [11:0]                s_therm,
    output logic [15:0]                s_power,
    output logic [`OBS_NUM_LANES-1:0]  s_link_up,
    output logic [`OBS_TS_W-1:0]       s_ts
);

    logic [`OBS_TS_W-1:0] ts_cnt;

    // Runs from reset regardless of trace enable
    always_ff @(posedge clk_management or negedge rst_n) begin
        if (!rst_n) begin
            ts_cnt <= '0;
        end else begin
            ts_cnt <= ts_cnt + 1'b1;
        end
    end

    // Qualifiers and stamp
    always_ff @(posedge clk_management or negedge rst_n) begin
        if (!rst_n) begin
            s_valid   <= 1'b0;
            s_error   <= 1'b0;
            s_link_up <= '0;
            s_ts      <= '0;
        end else begin
            s_valid   <= flit_valid;
            s_error   <= flit_error;
            s_link_up <= link_up;
            s_ts      <= ts_cnt;      // Time of capture, not of use
        end
    end

    // Payload fields
    always_ff @(posedge clk_management) begin
        s_data    <= flit_data;
        s_err_cnt <= err_cnt;
        s_therm   <= therm_c;
        s_power   <= power_mw;
    end

endmodule

`default_nettype wire

// File: rtl/obs_trigger_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "obs_config.svh"

module obs_trigger_unit (
    input  logic                       clk_management,
    input  logic                       rst_n,
    input  logic                       enable,      // Trace enable and mask bit
    input  obs_pkg::trig_cond_u        cond_word,
    input  logic                       s_error,
    input  logic [7:0]                 s_err_cnt,
    input  logic [11:0]                s_therm,
    input  logic [15:0]                s_power,
    input  logic [`OBS_NUM_LANES-1:0]  s_link_up,
    output logic                       level,
    output logic                       rise
);

    logic [7:0]  trig_type;
    logic [23:0] threshold;
    logic [1:0]  lane_sel;
    logic        cond_hit;

    assign trig_type = cond_word.thresh_view.trig_type;
    assign threshold = cond_word.thresh_view.threshold;
    assign lane_sel  = cond_word.lane_view.lane_sel;

    // Threshold compares are strictly greater than
    always_comb begin
        case (trig_type)
            `OBS_TRIG_ERR: begin
                cond_hit = (s_err_cnt > threshold[7:0]);
            end
            `OBS_TRIG_THERM: begin
                cond_hit = (s_therm > threshold[11:0]);
            end
            `OBS_TRIG_POWER: begin
                cond_hit = (s_power > threshold[15:0]);
            end
            `OBS_TRIG_PROTO: begin
                cond_hit = s_error;           // Flit error seen
            end
            `OBS_TRIG_LINK: begin
                cond_hit = !s_link_up[lane_sel];  // Lane dropped out of training
            end
            default: begin
                cond_hit = 1'b0;
            end
        endcase
    end

    // Level and its rising edge land on the same clock,
    // so the edge lines up with the first high level cycle
    always_ff @(posedge clk_management or negedge rst_n) begin
        if (!rst_n) begin
            level <= 1'b0;
            rise  <= 1'b0;
        end else begin
            level <= enable && cond_hit;
            rise  <= enable && cond_hit && !level;
        end
    end

endmodule

`default_nettype wire

// File: rtl/obs_trace_writer.sv
`timescale 1ns/1ps
`default_nettype none

`include "obs_config.svh"

module obs_trace_writer (
    input  logic                       clk_management,
    input  logic                       rst_n,
    input  logic                       trace_enable,
    input  logic                       s_valid,
    input  logic [15:0]                s_data,
    input  logic [`OBS_TS_W-1:0]       s_ts,
    input  logic [`OBS_NUM_TRIG-1:0]   trig_rise,
    input  logic [`OBS_TRACE_AW-1:0]   rd_index,
    output logic [`OBS_TRACE_AW-1:0]   wr_ptr,
    output logic                       full,
    output logic                       triggered,
    output logic [15:0]                entry_count,
    output logic [`OBS_TS_W-1:0]       rd_ts,
    output logic [`OBS_WB_DW-1:0]      rd_info
);

    logic [`OBS_TS_W-1:0]  ts_mem   [`OBS_TRACE_DEPTH];
    logic [`OBS_WB_DW-1:0] info_mem [`OBS_TRACE_DEPTH];

    // Sample delayed one stage to meet the trigger edge
    logic                  p_valid;
    logic [15:0]           p_data;
    logic [`OBS_TS_W-1:0]  p_ts;
    logic                  wr_en;
    logic [`OBS_WB_DW-1:0] info_word;

    always_ff @(posedge clk_management or negedge rst_n) begin
        if (!rst_n) begin
            p_valid <= 1'b0;
        end else begin
            p_valid <= s_valid;
        end
    end

    always_ff @(posedge clk_management) begin
        p_data <= s_data;
        p_ts   <= s_ts;
    end

    assign wr_en = trace_enable && (p_valid || (|trig_rise));

    // Hit mask on top, flit valid below it, data in the low half
    assign info_word = {trig_rise, p_valid,
                        {(`OBS_WB_DW - `OBS_NUM_TRIG - 17){1'b0}}, p_data};

    always_ff @(posedge clk_management) begin
        if (wr_en) begin
            ts_mem[wr_ptr]   <= p_ts;
            info_mem[wr_ptr] <= info_word;
        end
    end

    always_ff @(posedge clk_management or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr      <= '0;
            full        <= 1'b0;
            triggered   <= 1'b0;
            entry_count <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;   // Wraps on its own
                if (wr_ptr == (`OBS_TRACE_DEPTH - 1)) begin
                    full <= 1'b1;
                end
                if (entry_count != 16'hFFFF) begin
                    entry_count <= entry_count + 16'd1;
                end
            end
            // Sticky until reset
            if (trace_enable && (|trig_rise)) begin
                triggered <= 1'b1;
            end
        end
    end

    assign rd_ts   = ts_mem[rd_index];
    assign rd_info = info_mem[rd_index];

endmodule

`default_nettype wire

// File: rtl/obs_wb_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "obs_config.svh"

module obs_wb_regs (
    input  logic                       clk_management,
    input  logic                       rst_n,
    input  logic                       wb_cyc,
    input  logic                       wb_stb,
    input  logic                       wb_we,
    input  logic [`OBS_WB_AW-1:0]      wb_adr,
    input  logic [`OBS_WB_DW-1:0]      wb_dat_w,
    input  logic [`OBS_TRACE_AW-1:0]   wr_ptr,
    input  logic                       full,
    input  logic                       triggered,
    input  logic [15:0]                entry_count,
    input  logic [`OBS_TS_W-1:0]       rd_ts,
    input  logic [`OBS_WB_DW-1:0]      rd_info,
    output logic [`OBS_WB_DW-1:0]      wb_dat_r,
    output logic                       wb_ack,
    output logic                       trace_enable,
    output logic [`OBS_NUM_TRIG-1:0]   trig_mask,
    output obs_pkg::trig_cond_u        cond_word [`OBS_NUM_TRIG],
    output logic [`OBS_TRACE_AW-1:0]   rd_index
);

    logic                      wb_req;
    logic                      trace_area;
    logic [`OBS_NUM_TRIG-1:0]  cond_sel;
    logic [`OBS_WB_DW-1:0]     ctrl_word;
    logic [`OBS_WB_DW-1:0]     status_word;
    logic [`OBS_WB_DW-1:0]     rd_word;

    // New strobe only, the ack cycle itself is not a second request
    assign wb_req = wb_cyc && wb_stb && !wb_ack;

    assign trace_area = (wb_adr >= `OBS_REG_TRACE_BASE);
    assign rd_index   = wb_adr[`OBS_TRACE_AW + 2:3];   // Entry k at base + 8k

    always_comb begin
        for (int i = 0; i < `OBS_NUM_TRIG; i++) begin
            cond_sel[i] = (int'(wb_adr) == int'(`OBS_REG_COND_BASE) + 4 * i);
        end
    end

    assign ctrl_word   = {{(`OBS_WB_DW - 8){1'b0}}, trig_mask, 3'b000, trace_enable};
    assign status_word = {entry_count, 6'b0, triggered, full,
                          {(8 - `OBS_TRACE_AW){1'b0}}, wr_ptr};

    always_comb begin
        rd_word = '0;   // Holes in the map
        if (trace_area) begin
            rd_word = wb_adr[2] ? rd_info : rd_ts;
        end else if (wb_adr == `OBS_REG_CTRL) begin
            rd_word = ctrl_word;
        end else if (wb_adr == `OBS_REG_STATUS) begin
            rd_word = status_word;
        end else begin
            for (int i = 0; i < `OBS_NUM_TRIG; i++) begin
                if (cond_sel[i]) begin
                    rd_word = cond_word[i];
                end
            end
        end
    end

    always_ff @(posedge clk_management or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack       <= 1'b0;
            trace_enable <= 1'b0;
            trig_mask    <= '0;
            for (int i = 0; i < `OBS_NUM_TRIG; i++) begin
                cond_word[i] <= '0;
            end
        end else begin
            wb_ack <= wb_req;   // Single cycle ack
            if (wb_req && wb_we) begin
                if (wb_adr == `OBS_REG_CTRL) begin
                    trace_enable <= wb_dat_w[0];
                    trig_mask    <= wb_dat_w[4 +: `OBS_NUM_TRIG];
                end
                for (int i = 0; i < `OBS_NUM_TRIG; i++) begin
                    if (cond_sel[i]) begin
                        cond_word[i] <= wb_dat_w;
                    end
                end
            end
        end
    end

    // Read data valid with ack
    always_ff @(posedge clk_management) begin
        if (wb_req && !wb_we) begin
            wb_dat_r <= rd_word;
        end
    end

endmodule

`default_nettype wire

// File: rtl/obs_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "obs_config.svh"

module obs_top (
    input  logic                       clk_management,
    input  logic                       rst_n,
    // Link sample
    input  logic                       flit_valid,
    input  logic                       flit_error,
    input  logic [15:0]                flit_data,
    input  logic [7:0]                 err_cnt,
    input  logic [11:0]                therm_c,
    input  logic [15:0]                power_mw,
    input  logic [`OBS_NUM_LANES-1:0]  link_up,
    // Wishbone classic slave
    input  logic                       wb_cyc,
    input  logic                       wb_stb,
    input  logic                       wb_we,
    input  logic [`OBS_WB_AW-1:0]      wb_adr,
    input  logic [`OBS_WB_DW-1:0]      wb_dat_w,
    output logic [`OBS_WB_DW-1:0]      wb_dat_r,
    output logic                       wb_ack,
    // Trigger status
    output logic [`OBS_NUM_TRIG-1:0]   trigger_activated,
    output logic                       trace_triggered
);

    logic                       s_valid;
    logic                       s_error;
    logic [15:0]                s_data;
    logic [7:0]                 s_err_cnt;
    logic [11:0]                s_therm;
    logic [15:0]                s_power;
    logic [`OBS_NUM_LANES-1:0]  s_link_up;
    logic [`OBS_TS_W-1:0]       s_ts;

    logic                       trace_enable;
    logic [`OBS_NUM_TRIG-1:0]   trig_mask;
    obs_pkg::trig_cond_u        cond_word [`OBS_NUM_TRIG];
    logic [`OBS_NUM_TRIG-1:0]   trig_rise;

    logic [`OBS_TRACE_AW-1:0]   wr_ptr;
    logic [`OBS_TRACE_AW-1:0]   rd_index;
    logic                       full;
    logic [15:0]                entry_count;
    logic [`OBS_TS_W-1:0]       rd_ts;
    logic [`OBS_WB_DW-1:0]      rd_info;

    obs_sample_capture u_capture (
        .clk_management (clk_management),
        .rst_n          (rst_n),
        .flit_valid     (flit_valid),
        .flit_error     (flit_error),
        .flit_data      (flit_data),
        .err_cnt        (err_cnt),
        .therm_c        (therm_c),
        .power_mw       (power_mw),
        .link_up        (link_up),
        .s_valid        (s_valid),
        .s_error        (s_error),
        .s_data         (s_data),
        .s_err_cnt      (s_err_cnt),
        .s_therm        (s_therm),
        .s_power        (s_power),
        .s_link_up      (s_link_up),
        .s_ts           (s_ts)
    );

    for (genvar i = 0; i < `OBS_NUM_TRIG; i++) begin : gen_trig
        obs_trigger_unit u_trig (
            .clk_management (clk_management),
            .rst_n          (rst_n),
            .enable         (trace_enable && trig_mask[i]),
            .cond_word      (cond_word[i]),
            .s_error        (s_error),
            .s_err_cnt      (s_err_cnt),
            .s_therm        (s_therm),
            .s_power        (s_power),
            .s_link_up      (s_link_up),
            .level          (trigger_activated[i]),
            .rise           (trig_rise[i])
        );
    end

    obs_trace_writer u_writer (
        .clk_management (clk_management),
        .rst_n          (rst_n),
        .trace_enable   (trace_enable),
        .s_valid        (s_valid),
        .s_data         (s_data),
        .s_ts           (s_ts),
        .trig_rise      (trig_rise),
        .rd_index       (rd_index),
        .wr_ptr         (wr_ptr),
        .full           (full),
        .triggered      (trace_triggered),
        .entry_count    (entry_count),
        .rd_ts          (rd_ts),
        .rd_info        (rd_info)
    );

    obs_wb_regs u_regs (
        .clk_management (clk_management),
        .rst_n          (rst_n),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_w       (wb_dat_w),
        .wr_ptr         (wr_ptr),
        .full           (full),
        .triggered      (trace_triggered),
        .entry_count    (entry_count),
        .rd_ts          (rd_ts),
        .rd_info        (rd_info),
        .wb_dat_r       (wb_dat_r),
        .wb_ack         (wb_ack),
        .trace_enable   (trace_enable),
        .trig_mask      (trig_mask),
        .cond_word      (cond_word),
        .rd_index       (rd_index)
    );

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_management,
    output logic rst_n
);

    initial begin
        clk_management = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_management = ~clk_management;
        end
    end

    // Released on a falling edge, clear of the drive phase
    initial begin
        rst_n = 1'b0;
        #(PERIOD_NS * RESET_CYCLES) rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: testbench/tb_obs_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "obs_config.svh"

module tb_obs_top;

    localparam int ACK_TIMEOUT   = 20;
    localparam int RESET_TIMEOUT = 40;
    localparam int SETTLE_CYCLES = 4;     // Input to stored entry takes 3 edges
    localparam int NUM_FLITS     = 10;
    localparam int WRAP_FLITS    = 20;
    localparam int ROUND_SAMPLES = 12;

    logic                        clk_management;
    logic                        rst_n;
    logic                        flit_valid;
    logic                        flit_error;
    logic [15:0]                 flit_data;
    logic [7:0]                  err_cnt;
    logic [11:0]                 therm_c;
    logic [15:0]                 power_mw;
    logic [`OBS_NUM_LANES-1:0]   link_up;
    logic                        wb_cyc;
    logic                        wb_stb;
    logic                        wb_we;
    logic [`OBS_WB_AW-1:0]       wb_adr;
    logic [`OBS_WB_DW-1:0]       wb_dat_w;
    logic [`OBS_WB_DW-1:0]       wb_dat_r;
    logic                        wb_ack;
    logic [`OBS_NUM_TRIG-1:0]    trigger_activated;
    logic                        trace_triggered;

    logic [31:0]                 rng_state;
    int                          cycle_count;
    int                          error_count;
    int                          exp_count;        // Entries written so far
    logic                        exp_triggered;
    logic                        level_check_en;
    logic [`OBS_NUM_TRIG-1:0]    exp_level;
    obs_pkg::trig_cond_u         conds [`OBS_NUM_TRIG];
    logic [7:0]                  type_list [6];

    tb_clock_gen #(
        .PERIOD_NS    (100),
        .RESET_CYCLES (16)
    ) u_clock_gen (
        .clk_management (clk_management),
        .rst_n          (rst_n)
    );

    obs_top u_obs_top (
        .clk_management    (clk_management),
        .rst_n             (rst_n),
        .flit_valid        (flit_valid),
        .flit_error        (flit_error),
        .flit_data         (flit_data),
        .err_cnt           (err_cnt),
        .therm_c           (therm_c),
        .power_mw          (power_mw),
        .link_up           (link_up),
        .wb_cyc            (wb_cyc),
        .wb_stb            (wb_stb),
        .wb_we             (wb_we),
        .wb_adr            (wb_adr),
        .wb_dat_w          (wb_dat_w),
        .wb_dat_r          (wb_dat_r),
        .wb_ack            (wb_ack),
        .trigger_activated (trigger_activated),
        .trace_triggered   (trace_triggered)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Expected trigger level for one condition word and one held sample
    function automatic logic ref_trigger(input obs_pkg::trig_cond_u cond,
                                         input logic error,
                                         input logic [7:0] ec,
                                         input logic [11:0] therm,
                                         input logic [15:0] power,
                                         input logic [`OBS_NUM_LANES-1:0] lanes);
        logic hit;
        hit = 1'b0;
        case (cond.thresh_view.trig_type)
            `OBS_TRIG_ERR:   hit = ec > cond.thresh_view.threshold[7:0];
            `OBS_TRIG_THERM: hit = therm > cond.thresh_view.threshold[11:0];
            `OBS_TRIG_POWER: hit = power > cond.thresh_view.threshold[15:0];
            `OBS_TRIG_PROTO: hit = error;
            `OBS_TRIG_LINK:  hit = !lanes[cond.lane_view.lane_sel];  // Lane not up
            default:         hit = 1'b0;
        endcase
        return hit;
    endfunction

    function automatic logic [7:0] cond_addr(input int idx);
        return 8'(`OBS_REG_COND_BASE + 4 * idx);
    endfunction

    function automatic logic [7:0] entry_addr(input int idx, input logic info);
        return 8'(`OBS_REG_TRACE_BASE + 8 * idx + (info ? 4 : 0));
    endfunction

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("[FAIL] %s expected 0x%08h actual 0x%08h", name, expected, actual);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic next_cycle();
        @(posedge clk_management);
        #1;
        cycle_count++;
    endtask

    task automatic wait_reset_release();
        int waited;
        waited = 0;
        while (rst_n !== 1'b1) begin
            if (waited >= RESET_TIMEOUT) begin
                abort_on_timeout("reset release");
            end else begin
                next_cycle();
                waited++;
            end
        end
    endtask

    // Ack comes one clock after the strobe and lasts a single cycle
    task automatic end_transfer(input int waited);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        check_equal("wb_ack_latency", 32'h0, 32'(waited));
        next_cycle();
        check_equal("wb_ack_pulse", 32'h0, 32'(wb_ack));
    endtask

    task automatic wb_write(input logic [7:0] adr, input logic [31:0] data);
        int waited;
        waited   = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = data;
        next_cycle();
        while (wb_ack !== 1'b1) begin
            if (waited >= ACK_TIMEOUT) begin
                abort_on_timeout("Wishbone write ack");
            end else begin
                next_cycle();
                waited++;
            end
        end
        end_transfer(waited);
    endtask

    task automatic wb_read(input logic [7:0] adr, output logic [31:0] data);
        int waited;
        waited = 0;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        next_cycle();
        while (wb_ack !== 1'b1) begin
            if (waited >= ACK_TIMEOUT) begin
                abort_on_timeout("Wishbone read ack");
            end else begin
                next_cycle();
                waited++;
            end
        end
        data = wb_dat_r;    // Registered together with ack
        end_transfer(waited);
    endtask

    task automatic verify_status(input string name);
        logic [31:0] rd;
        logic [31:0] expected;
        // Pointer wraps with the count and full sets at depth
        expected = {exp_count[15:0], 6'h0, exp_triggered,
                    (exp_count >= `OBS_TRACE_DEPTH), 4'h0, exp_count[3:0]};
        wb_read(`OBS_REG_STATUS, rd);
        check_equal(name, expected, rd);
    endtask

    task automatic random_sample();
        logic [31:0] r;
        r          = next_random();
        err_cnt    = r[7:0];
        therm_c    = r[19:8];
        flit_error = r[20];
        link_up    = r[24:21];
        r          = next_random();
        power_mw   = r[15:0];
        flit_data  = r[31:16];
    endtask

    // Levels compared mid-cycle away from the drive phase
    always @(negedge clk_management) begin
        if (level_check_en) begin
            check_equal("trigger_level", 32'(exp_level), 32'(trigger_activated));
        end
    end

    task automatic reset_defaults();
        logic [31:0] rd;
        wb_read(`OBS_REG_CTRL, rd);
        check_equal("reset_ctrl", 32'h0, rd);
        wb_read(`OBS_REG_STATUS, rd);
        check_equal("reset_status", 32'h0, rd);
        for (int i = 0; i < `OBS_NUM_TRIG; i++) begin
            wb_read(cond_addr(i), rd);
            check_equal("reset_cond", 32'h0, rd);
        end
        wb_read(8'h40, rd);   // Hole in the map
        check_equal("unmapped_read", 32'h0, rd);
        check_equal("reset_trigger", 32'h0, 32'(trigger_activated));
        check_equal("reset_trace_triggered", 32'h0, 32'(trace_triggered));
    endtask

    task automatic register_readback();
        logic [31:0] w;
        logic [31:0] rd;
        logic [31:0] words [`OBS_NUM_TRIG];
        w = next_random();
        wb_write(`OBS_REG_CTRL, w);
        wb_read(`OBS_REG_CTRL, rd);
        check_equal("ctrl_readback", w & 32'h0000_00F1, rd);
        for (int i = 0; i < `OBS_NUM_TRIG; i++) begin
            words[i] = next_random();
            wb_write(cond_addr(i), words[i]);
        end
        for (int i = 0; i < `OBS_NUM_TRIG; i++) begin
            wb_read(cond_addr(i), rd);
            check_equal("cond_readback", words[i], rd);
        end
        wb_write(`OBS_REG_CTRL, 32'h0);
        verify_status("readback_status");   // Quiet sample so nothing fires
    endtask

    task automatic flit_trace();
        logic [15:0] data_q [NUM_FLITS];
        int          cyc_q  [NUM_FLITS];
        int          start;
        logic [31:0] r;
        logic [31:0] ts;
        logic [31:0] prev_ts;
        logic [31:0] info;
        wb_write(`OBS_REG_CTRL, 32'h1);    // Trace on with every unit masked off
        start = exp_count;
        for (int k = 0; k < NUM_FLITS; k++) begin
            r          = next_random();
            flit_valid = 1'b1;
            flit_data  = r[15:0];
            data_q[k]  = r[15:0];
            cyc_q[k]   = cycle_count;
            next_cycle();
            flit_valid = 1'b0;
            repeat (r[17:16]) next_cycle();   // Idle gap of 0 to 3
        end
        repeat (SETTLE_CYCLES) next_cycle();
        exp_count += NUM_FLITS;
        verify_status("flit_status");
        prev_ts = '0;
        for (int k = 0; k < NUM_FLITS; k++) begin
            wb_read(entry_addr((start + k) % `OBS_TRACE_DEPTH, 1'b0), ts);
            wb_read(entry_addr((start + k) % `OBS_TRACE_DEPTH, 1'b1), info);
            check_equal("flit_entry", {4'h0, 1'b1, 11'h0, data_q[k]}, info);
            if (k > 0) begin
                check_equal("flit_ts_order", 32'd1, 32'(ts > prev_ts));
                check_equal("flit_ts_step", 32'(cyc_q[k] - cyc_q[k - 1]), ts - prev_ts);
            end
            prev_ts = ts;
        end
    endtask

    task automatic trigger_compare();
        logic [31:0]              r;
        logic [31:0]              info;
        logic [`OBS_NUM_TRIG-1:0] mask;
        logic [`OBS_NUM_TRIG-1:0] lvl;
        logic [`OBS_NUM_TRIG-1:0] prev_lvl;
        logic [`OBS_NUM_TRIG-1:0] rise;
        // Three rounds walk every type code over the four units
        for (int round = 0; round < 3; round++) begin
            level_check_en = 1'b0;
            wb_write(`OBS_REG_CTRL, 32'h0);
            for (int i = 0; i < `OBS_NUM_TRIG; i++) begin
                conds[i] = next_random();
                conds[i].thresh_view.trig_type = type_list[(round * `OBS_NUM_TRIG + i) % 6];
                wb_write(cond_addr(i), conds[i]);
            end
            random_sample();
            r        = next_random();
            mask     = (r[3:0] == 4'h0) ? 4'hF : r[3:0];
            prev_lvl = '0;
            wb_write(`OBS_REG_CTRL, {24'h0, mask, 4'h1});
            for (int s = 0; s < ROUND_SAMPLES; s++) begin
                if (s > 0) begin
                    level_check_en = 1'b0;
                    random_sample();
                end
                repeat (SETTLE_CYCLES) next_cycle();
                for (int i = 0; i < `OBS_NUM_TRIG; i++) begin
                    lvl[i] = mask[i] && ref_trigger(conds[i], flit_error, err_cnt,
                                                    therm_c, power_mw, link_up);
                end
                rise           = lvl & ~prev_lvl;
                exp_level      = lvl;
                level_check_en = 1'b1;
                if (rise != '0) begin
                    exp_count++;
                    exp_triggered = 1'b1;
                    wb_read(entry_addr((exp_count - 1) % `OBS_TRACE_DEPTH, 1'b1), info);
                    check_equal("hit_mask", 32'({rise, 1'b0}), 32'(info[31:27]));
                end
                verify_status("trigger_status");
                prev_lvl = lvl;
            end
        end
        level_check_en = 1'b0;
        check_equal("trace_triggered", 32'(exp_triggered), 32'(trace_triggered));
    endtask

    task automatic buffer_wrap();
        logic [31:0] info;
        logic [15:0] last_data;
        wb_write(`OBS_REG_CTRL, 32'h1);
        last_data = '0;
        for (int k = 0; k < WRAP_FLITS; k++) begin
            random_sample();
            flit_valid = 1'b1;
            last_data  = flit_data;
            next_cycle();
        end
        flit_valid = 1'b0;
        repeat (SETTLE_CYCLES) next_cycle();
        exp_count += WRAP_FLITS;
        verify_status("wrap_status");
        wb_read(entry_addr((exp_count - 1) % `OBS_TRACE_DEPTH, 1'b1), info);
        check_equal("wrap_last_entry", {4'h0, 1'b1, 11'h0, last_data}, info);
    endtask

    task automatic trace_disabled();
        obs_pkg::trig_cond_u c;
        wb_write(`OBS_REG_CTRL, 32'h0000_00F0);   // All units in the mask with trace off
        c = '0;
        c.thresh_view.trig_type = `OBS_TRIG_PROTO;
        wb_write(cond_addr(0), c);
        c = '0;
        c.lane_view.lane_sel  = 2'd0;
        c.lane_view.trig_type = `OBS_TRIG_LINK;
        wb_write(cond_addr(1), c);
        c = '0;
        c.thresh_view.trig_type = `OBS_TRIG_ERR;
        wb_write(cond_addr(2), c);
        c = '0;
        c.thresh_view.trig_type = `OBS_TRIG_POWER;
        wb_write(cond_addr(3), c);
        flit_error     = 1'b1;
        err_cnt        = 8'hFF;
        therm_c        = 12'hFFF;
        power_mw       = 16'hFFFF;
        link_up        = 4'b1110;   // Lane 0 down
        exp_level      = '0;
        level_check_en = 1'b1;
        for (int k = 0; k < 12; k++) begin
            flit_valid = 1'b1;
            flit_data  = 16'(k);
            next_cycle();
        end
        flit_valid = 1'b0;
        repeat (SETTLE_CYCLES) next_cycle();
        verify_status("disabled_status");
        check_equal("disabled_level", 32'h0, 32'(trigger_activated));
        level_check_en = 1'b0;
    endtask

    initial begin
        flit_valid     = 1'b0;
        flit_error     = 1'b0;
        flit_data      = '0;
        err_cnt        = '0;
        therm_c        = '0;
        power_mw       = '0;
        link_up        = '1;     // All lanes trained
        wb_cyc         = 1'b0;
        wb_stb         = 1'b0;
        wb_we          = 1'b0;
        wb_adr         = '0;
        wb_dat_w       = '0;
        rng_state      = 32'h5645;
        cycle_count    = 0;
        error_count    = 0;
        exp_count      = 0;
        exp_triggered  = 1'b0;
        level_check_en = 1'b0;
        exp_level      = '0;
        type_list[0]   = `OBS_TRIG_ERR;
        type_list[1]   = `OBS_TRIG_THERM;
        type_list[2]   = `OBS_TRIG_POWER;
        type_list[3]   = `OBS_TRIG_PROTO;
        type_list[4]   = `OBS_TRIG_LINK;
        type_list[5]   = 8'd2;   // Unknown code that never fires
        wait_reset_release();
        next_cycle();
        reset_defaults();
        register_readback();
        flit_trace();
        trigger_compare();
        buffer_wrap();
        trace_disabled();
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+rtl
rtl/obs_pkg.sv
rtl/obs_sample_capture.sv
rtl/obs_trigger_unit.sv
rtl/obs_trace_writer.sv
rtl/obs_wb_regs.sv
rtl/obs_top.sv
testbench/tb_clock_gen.sv
testbench/tb_obs_top.sv

// File: Makefile
# Verilator build and run for the link trace monitor

VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := tb_obs_top
FILELIST  := src.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_TEXT := sim passed

SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard rtl/*.svh)
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation result: PASS"; \
	else \
		echo "Simulation result: FAIL, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
